// File: div_params.svh
/* widths and op encodings of the divide unit
   op code bit 2 marks the 32-bit "w" forms, bit 1 remainder, bit 0 unsigned */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// register width and the width of "w" operands
`define DIV_XLEN    64
`define DIV_HALF    32

// counter must be able to hold DIV_XLEN
`define DIV_CNT_W   7

// operation codes
`define DIV_OP_DIV      3'b000
`define DIV_OP_DIVU     3'b001
`define DIV_OP_REM      3'b010
`define DIV_OP_REMU     3'b011
`define DIV_OP_DIVW     3'b100
`define DIV_OP_DIVUW    3'b101
`define DIV_OP_REMW     3'b110
`define DIV_OP_REMUW    3'b111

`endif

// File: div_pkg.sv
/* types shared by the divide unit stages
   enum code values are taken from div_params.svh */
`include "div_params.svh"

package div_pkg;

    // register value and iteration count
    typedef logic [`DIV_XLEN-1:0]  xword_t;
    typedef logic [`DIV_CNT_W-1:0] step_cnt_t;

    typedef enum logic [2:0] {
        op_div   = `DIV_OP_DIV,
        op_divu  = `DIV_OP_DIVU,
        op_rem   = `DIV_OP_REM,
        op_remu  = `DIV_OP_REMU,
        op_divw  = `DIV_OP_DIVW,
        op_divuw = `DIV_OP_DIVUW,
        op_remw  = `DIV_OP_REMW,
        op_remuw = `DIV_OP_REMUW
    } div_op_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_load = 2'd1,
        st_iter = 2'd2,
        st_fix  = 2'd3
    } div_state_t;

    // prepared operands, latched at start
    typedef struct packed {
        xword_t dvd_mag;
        xword_t dvs_mag;
        logic   quot_neg;
        logic   rem_neg;
        logic   div_zero;
        // extended dividend, the remainder on divide by zero
        xword_t dvd_orig;
        logic   word;
        logic   rem_sel;
    } div_prep_t;

    // unsigned results straight from the iteration
    typedef struct packed {
        xword_t quot;
        xword_t rem;
    } div_core_t;

endpackage

// File: div_operand_prep.sv
/* operand stage of the divider, captures rs1/rs2 and op only on load_en
   "w" forms use the low 32 bits of each operand and ignore the rest */
`timescale 1ns/10ps
`include "div_params.svh"

module div_operand_prep (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load_en,
    input  div_pkg::div_op_t   op,
    input  div_pkg::xword_t    rs1,
    input  div_pkg::xword_t    rs2,
    output div_pkg::div_prep_t prep
);
    import div_pkg::*;

    logic      is_word;
    logic      is_signed;
    logic      is_rem;
    xword_t    dvd_ext;
    xword_t    dvs_ext;
    logic      dvd_neg;
    logic      dvs_neg;
    div_prep_t prep_next;

    // op decode
    assign is_word   = (op inside {op_divw, op_divuw, op_remw, op_remuw});
    assign is_signed = (op inside {op_div, op_rem, op_divw, op_remw});
    assign is_rem    = (op inside {op_rem, op_remu, op_remw, op_remuw});

    // narrow "w" operands, sign or zero extended by op
    always_comb begin
        if (is_word) begin
            dvd_ext = {{(`DIV_XLEN-`DIV_HALF){is_signed & rs1[`DIV_HALF-1]}},
                       rs1[`DIV_HALF-1:0]};
            dvs_ext = {{(`DIV_XLEN-`DIV_HALF){is_signed & rs2[`DIV_HALF-1]}},
                       rs2[`DIV_HALF-1:0]};
        end else begin
            dvd_ext = rs1;
            dvs_ext = rs2;
        end
    end

    // after extension bit 63 is the sign for both widths
    assign dvd_neg = is_signed & dvd_ext[`DIV_XLEN-1];
    assign dvs_neg = is_signed & dvs_ext[`DIV_XLEN-1];

    always_comb begin
        prep_next.dvd_mag  = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
        prep_next.dvs_mag  = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;
        // quotient sign from the operand signs, remainder follows the dividend
        prep_next.quot_neg = dvd_neg ^ dvs_neg;
        prep_next.rem_neg  = dvd_neg;
        prep_next.div_zero = (dvs_ext == '0);
        prep_next.dvd_orig = dvd_ext;
        prep_next.word     = is_word;
        prep_next.rem_sel  = is_rem;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prep <= '0;
        end else if (load_en) begin
            prep <= prep_next;
        end
    end

endmodule

// File: div_step_counter.sv
/* iteration counter of the divider, loads 64 or 32 and counts down
   last is high while one step remains */
`timescale 1ns/10ps
`include "div_params.svh"

module div_step_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic step,
    input  logic word,
    output logic last
);
    import div_pkg::*;

    step_cnt_t count;

    // load wins over step, the sequencer never raises both
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= word ? step_cnt_t'(`DIV_HALF) : step_cnt_t'(`DIV_XLEN);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    assign last = (count == step_cnt_t'(1));

    // sequencer must leave the iterate state on last
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        step |-> (count != '0)
    ) else $error("step counter decremented at zero");

endmodule

// File: div_ctrl_fsm.sv
/* sequencer of the serial divider, one operation at a time
   start is taken only in idle, a start during an operation is dropped */
`timescale 1ns/10ps

module div_ctrl_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    input  logic last,
    output logic load_en,
    output logic init,
    output logic step,
    output logic fix_en,
    output logic busy,
    output logic done
);
    import div_pkg::*;

    div_state_t state;
    div_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = st_iter;
            end
            st_iter: begin
                // last step of the count, go fix the signs
                if (last) begin
                    state_next = st_fix;
                end
            end
            st_fix: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            // done lands with the registered result
            done  <= fix_en;
        end
    end

    // strobes to the stages
    assign load_en = (state == st_idle) && start;
    assign init    = (state == st_load);
    assign step    = (state == st_iter);
    assign fix_en  = (state == st_fix);
    assign busy    = (state != st_idle);

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    ) else $error("done held for more than one cycle");

    // iterate is entered only through load
    a_no_step_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        step |-> ($past(state) != st_idle)
    ) else $error("step issued right after idle");

endmodule

// File: div_shift_subtract.sv
/* restoring shift-subtract core, one quotient bit per step on magnitudes only
   "w" dividends are pre-shifted so 32 steps leave the quotient in the low half */
`timescale 1ns/10ps
`include "div_params.svh"

module div_shift_subtract (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               init,
    input  logic               step,
    input  div_pkg::div_prep_t prep,
    output div_pkg::div_core_t core
);
    import div_pkg::*;

    xword_t             rem_q;
    xword_t             quot_q;
    logic [`DIV_XLEN:0] trial;
    logic [`DIV_XLEN:0] diff;
    logic               fits;

    // remainder shifted left with the next dividend bit, one extra bit of headroom
    assign trial = {rem_q, quot_q[`DIV_XLEN-1]};
    assign diff  = trial - {1'b0, prep.dvs_mag};
    assign fits  = (trial >= {1'b0, prep.dvs_mag});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rem_q  <= '0;
            quot_q <= '0;
        end else if (init) begin
            rem_q <= '0;
            // low half to the top for the 32-step forms
            if (prep.word) begin
                quot_q <= {prep.dvd_mag[`DIV_HALF-1:0],
                           {(`DIV_XLEN-`DIV_HALF){1'b0}}};
            end else begin
                quot_q <= prep.dvd_mag;
            end
        end else if (step) begin
            // restore by keeping the trial when the divisor does not fit
            if (fits) begin
                rem_q <= diff[`DIV_XLEN-1:0];
            end else begin
                rem_q <= trial[`DIV_XLEN-1:0];
            end
            quot_q <= {quot_q[`DIV_XLEN-2:0], fits};
        end
    end

    assign core.quot = quot_q;
    assign core.rem  = rem_q;

endmodule

// File: div_result_fix.sv
/* result stage, applies signs and the divide-by-zero values on fix_en
   result holds until the next fix_en */
`timescale 1ns/10ps
`include "div_params.svh"

module div_result_fix (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fix_en,
    input  div_pkg::div_prep_t prep,
    input  div_pkg::div_core_t core,
    output div_pkg::xword_t    result
);
    import div_pkg::*;

    xword_t raw;
    logic   negate;
    xword_t signed_val;
    xword_t fixed_val;
    xword_t result_next;

    always_comb begin
        raw        = prep.rem_sel ? core.rem : core.quot;
        negate     = prep.rem_sel ? prep.rem_neg : prep.quot_neg;
        signed_val = negate ? (~raw + 1'b1) : raw;
        // x/0 gives all ones, x%0 gives the dividend back
        if (prep.div_zero) begin
            fixed_val = prep.rem_sel ? prep.dvd_orig : '1;
        end else begin
            // overflow case lands here too, magnitude 2^63 stays 2^63
            fixed_val = signed_val;
        end
    end

    // "w" results always sign-extended from bit 31
    always_comb begin
        if (prep.word) begin
            result_next = {{(`DIV_XLEN-`DIV_HALF){fixed_val[`DIV_HALF-1]}},
                           fixed_val[`DIV_HALF-1:0]};
        end else begin
            result_next = fixed_val;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (fix_en) begin
            result <= result_next;
        end
    end

endmodule

// File: div_unit.sv
/* RV64 M-extension divide unit, start strobe in, done pulse out
   66 cycles start to done for full width, 34 for the "w" forms */
`timescale 1ns/10ps

module div_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::xword_t  rs1,
    input  div_pkg::xword_t  rs2,
    output logic             busy,
    output logic             done,
    output div_pkg::xword_t  result
);
    import div_pkg::*;

    // sequencer strobes
    logic      load_en;
    logic      init;
    logic      step;
    logic      fix_en;
    logic      last;
    // stage payloads
    div_prep_t prep;
    div_core_t core;

    div_ctrl_fsm ctrl_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .last    (last),
        .load_en (load_en),
        .init    (init),
        .step    (step),
        .fix_en  (fix_en),
        .busy    (busy),
        .done    (done)
    );

    // counter loads on the same cycle the core initialises
    div_step_counter counter_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (init),
        .step   (step),
        .word   (prep.word),
        .last   (last)
    );

    div_operand_prep prep_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .load_en (load_en),
        .op      (op),
        .rs1     (rs1),
        .rs2     (rs2),
        .prep    (prep)
    );

    div_shift_subtract core_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .init   (init),
        .step   (step),
        .prep   (prep),
        .core   (core)
    );

    div_result_fix fix_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .fix_en (fix_en),
        .prep   (prep),
        .core   (core),
        .result (result)
    );

endmodule

// File: tb_div_unit.sv
/* random-stimulus testbench of the divide unit, LCG seeded 32'h65e5_fab0
   results checked against a division model, one operation in flight at a time */
`timescale 1ns/10ps

module tb_div_unit;
    import div_pkg::*;

    localparam int     DONE_TIMEOUT = 200;
    localparam int     RANDOM_OPS   = 376;
    localparam xword_t MIN64        = 64'h8000_0000_0000_0000;

    logic        clk;
    logic        arst_n;
    logic        start;
    div_op_t     op;
    xword_t      rs1;
    xword_t      rs2;
    logic        busy;
    logic        done;
    xword_t      result;
    logic [31:0] lcg_state;

    div_unit div_unit_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // two LCG steps, upper halves only since the low bits repeat quickly
    function logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic xword_t pick_operand();
        logic [31:0] sel;
        logic [31:0] hi;
        logic [31:0] lo;
        sel = next_rand();
        hi  = next_rand();
        lo  = next_rand();
        case (sel[3:0])
            4'd0:    return '0;
            4'd1:    return 64'd1;
            4'd2:    return '1;
            4'd3:    return MIN64;
            4'd4:    return 64'hffff_ffff_8000_0000;
            4'd5:    return 64'h0000_0000_8000_0000;
            4'd6:    return {60'd0, lo[3:0]};
            4'd7:    return {60'hfff_ffff_ffff_ffff, lo[3:0]};
            4'd8:    return {hi, 32'hffff_ffff};
            default: return {hi, lo};
        endcase
    endfunction

    function automatic logic is_word_op(input div_op_t o);
        return o inside {op_divw, op_divuw, op_remw, op_remuw};
    endfunction

    // ISA results, x/0 and the signed overflow handled before dividing
    function automatic xword_t model_result(input div_op_t o, input xword_t a, input xword_t b);
        longint      sa;
        longint      sb;
        int          sa32;
        int          sb32;
        logic [31:0] r32;
        xword_t      r;
        sa   = a;
        sb   = b;
        sa32 = a[31:0];
        sb32 = b[31:0];
        r    = '0;
        r32  = '0;
        case (o)
            op_div:   r = (b == '0) ? '1 : (a == MIN64 && b == '1) ? MIN64 : xword_t'(sa / sb);
            op_rem:   r = (b == '0) ? a : (a == MIN64 && b == '1) ? '0 : xword_t'(sa % sb);
            op_divu:  r = (b == '0) ? '1 : a / b;
            op_remu:  r = (b == '0) ? a : a % b;
            op_divw:  r32 = (sb32 == 0) ? '1 : (sa32 == 32'sh8000_0000 && sb32 == -1) ?
                            32'h8000_0000 : 32'(sa32 / sb32);
            op_remw:  r32 = (sb32 == 0) ? a[31:0] : (sa32 == 32'sh8000_0000 && sb32 == -1) ?
                            '0 : 32'(sa32 % sb32);
            op_divuw: r32 = (b[31:0] == '0) ? '1 : a[31:0] / b[31:0];
            op_remuw: r32 = (b[31:0] == '0) ? a[31:0] : a[31:0] % b[31:0];
            default:  r = '0;
        endcase
        if (is_word_op(o)) begin
            r = {{32{r32[31]}}, r32};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // one operation from start to done, optionally with a stray start while busy
    task automatic run_op(input div_op_t o, input xword_t a, input xword_t b, input logic inject);
        xword_t      exp_res;
        int          exp_lat;
        int          inject_at;
        int          n;
        logic [31:0] r;
        exp_res   = model_result(o, a, b);
        exp_lat   = is_word_op(o) ? 34 : 66;
        r         = next_rand();
        inject_at = 1 + int'(r % 32'(exp_lat - 2));
        @(posedge clk);
        start <= 1'b1;
        op    <= o;
        rs1   <= a;
        rs2   <= b;
        @(negedge clk);
        check_value("busy before start edge", xword_t'(busy), '0);
        // start edge
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!done) begin
            check_value("busy", xword_t'(busy), 64'd1);
            if (n >= DONE_TIMEOUT) begin
                $display("ERROR: done never came within %0d cycles of start", DONE_TIMEOUT);
                $display("Simulation FAILED");
                $fatal(1, "timeout");
            end
            @(posedge clk);
            n++;
            if (inject && n == inject_at) begin
                r = next_rand();
                start <= 1'b1;
                op    <= div_op_t'(r[2:0]);
                rs1   <= pick_operand();
                rs2   <= pick_operand();
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        check_value("latency", xword_t'(n), xword_t'(exp_lat));
        check_value("busy at done", xword_t'(busy), '0);
        check_value("result", result, exp_res);
        // done is a single pulse, nothing follows and result holds
        repeat (1 + int'(next_rand() % 32'd3)) begin
            @(negedge clk);
            check_value("done after pulse", xword_t'(done), '0);
            check_value("busy after done", xword_t'(busy), '0);
            check_value("result hold", result, exp_res);
        end
    endtask

    initial begin
        logic [31:0] r;
        arst_n    = 1'b0;
        start     = 1'b0;
        op        = op_div;
        rs1       = '0;
        rs2       = '0;
        lcg_state = 32'h65e5_fab0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("busy after reset", xword_t'(busy), '0);
        check_value("done after reset", xword_t'(done), '0);
        check_value("result after reset", result, '0);

        // x/0 and both overflow cases for every op
        for (int i = 0; i < 8; i++) begin
            run_op(div_op_t'(i), pick_operand(), '0, 1'b0);
            run_op(div_op_t'(i), MIN64, '1, 1'b0);
            run_op(div_op_t'(i), 64'hffff_ffff_8000_0000, '1, 1'b0);
        end

        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = next_rand();
            run_op(div_op_t'(r[2:0]), pick_operand(), pick_operand(), r[9:8] == 2'b00);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_step_counter.sv
div_ctrl_fsm.sv
div_shift_subtract.sv
div_result_fix.sv
div_unit.sv
tb_div_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_div_unit -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if grep -q "Simulation PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
